/* include/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// address of the first instruction fetched after reset.
`define CPU_RESET_PC 32'h0000_0000

// number of architectural integer registers.
`define CPU_REG_COUNT 32

`define CPU_ADDR_WIDTH 32

`endif

/* source/isa_pkg.sv */
package isa_pkg;

  // major opcodes of the supported RV32I subset.
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_mode_t;

  typedef enum logic {ALU_A_REG, ALU_A_PC} alu_a_sel_t;
  typedef enum logic {ALU_B_REG, ALU_B_IMM} alu_b_sel_t;
  typedef enum logic [1:0] {RD_ALU, RD_MEM, RD_NEXT_PC} rd_sel_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm;
  } decoded_t;

  typedef struct packed {
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    rd_sel_t    rd_sel;
    alu_mode_t  alu_mode;
    logic       rd_we;
    logic       branch;
    logic       invert_compare; // taken when the compare result is zero.
    logic       load_pc;
    logic       step_pc;
  } control_t;

endpackage

/* source/bus_pkg.sv */
`include "cpu_cfg.svh"

package bus_pkg;

  typedef struct packed {
    logic                       read;
    logic [`CPU_ADDR_WIDTH-1:0] address;
  } avalon_read_req_t;

  typedef struct packed {
    logic                       read;
    logic                       write;
    logic [`CPU_ADDR_WIDTH-1:0] address;
    logic [31:0]                writedata;
    logic [3:0]                 byteenable;
  } avalon_rw_req_t;

  // shared by both ports; the instruction port never writes.
  typedef struct packed {
    logic        waitrequest;
    logic [31:0] readdata;
  } avalon_rsp_t;

endpackage

/* source/instruction_fetch_unit.sv */
`timescale 1ns/1ps

module instruction_fetch_unit
  import bus_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [31:0]      pc,
  input  logic             fetch_start,
  output avalon_read_req_t req,
  input  avalon_rsp_t      rsp,
  output logic             done,
  output logic [31:0]      ir
);
  logic        read_q;
  logic [31:0] address_q;

  // the read completes in the first cycle without waitrequest.
  assign done = read_q & ~rsp.waitrequest;
  assign req  = '{read: read_q, address: address_q};

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      read_q <= 1'b0;
    end else if (fetch_start) begin
      read_q <= 1'b1;
    end else if (done) begin
      read_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_start) begin
      address_q <= pc;
    end
    if (done) begin
      ir <= rsp.readdata;
    end
  end

endmodule

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder
  import isa_pkg::*;
(
  input  logic [31:0] ir,
  output decoded_t    dec
);
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  always_comb begin
    dec.opcode = opcode_t'(ir[6:0]); // unknown opcodes pass through and retire as no-ops.
    dec.rd     = ir[11:7];
    dec.f3     = ir[14:12];
    dec.rs1    = ir[19:15];
    dec.rs2    = ir[24:20];
    dec.f7     = ir[31:25];

    case (dec.opcode)
      OP_STORE: begin
        dec.imm = imm_s;
      end
      OP_BRANCH: begin
        dec.imm = imm_b;
      end
      OP_LUI, OP_AUIPC: begin
        dec.imm = imm_u;
      end
      OP_JAL: begin
        dec.imm = imm_j;
      end
      default: begin
        dec.imm = imm_i; // loads, jalr and register-immediate operations.
      end
    endcase
  end

endmodule

/* source/control_unit.sv */
`timescale 1ns/1ps

module control_unit
  import isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  decoded_t dec,
  input  logic     debug_wait,
  input  logic     fetch_done,
  input  logic     mem_done,
  output logic     fetch_start,
  output logic     mem_start,
  output logic     mem_write,
  output control_t ctrl
);
  typedef enum logic [2:0] {FETCH, WAIT_FETCH, EXECUTE, MEM, WRITEBACK} state_t;

  state_t   state;
  state_t   state_next;
  control_t base;
  logic     writes_rd;
  logic     is_jump;
  logic     is_mem;

  // datapath selects depend only on the instruction; the enables depend on the state.
  always_comb begin
    base      = '0;
    writes_rd = 1'b0;
    is_jump   = 1'b0;
    is_mem    = 1'b0;
    case (dec.opcode)
      OP_LUI: begin
        base.alu_b_sel = ALU_B_IMM;
        base.alu_mode  = ALU_PASS_B;
        writes_rd      = 1'b1;
      end
      OP_AUIPC, OP_JAL: begin
        base.alu_a_sel = ALU_A_PC;
        base.alu_b_sel = ALU_B_IMM;
        base.rd_sel    = (dec.opcode == OP_JAL) ? RD_NEXT_PC : RD_ALU;
        writes_rd      = 1'b1;
        is_jump        = (dec.opcode == OP_JAL);
      end
      OP_JALR: begin
        base.alu_b_sel = ALU_B_IMM;
        base.rd_sel    = RD_NEXT_PC;
        writes_rd      = 1'b1;
        is_jump        = 1'b1;
      end
      OP_BRANCH: begin
        base.branch         = 1'b1;
        base.invert_compare = dec.f3[0] ^ ~dec.f3[2];
        case (dec.f3[2:1])
          2'b10:   base.alu_mode = ALU_SLT;
          2'b11:   base.alu_mode = ALU_SLTU;
          default: base.alu_mode = ALU_SUB;
        endcase
      end
      OP_LOAD, OP_STORE: begin
        base.alu_b_sel = ALU_B_IMM;
        base.rd_sel    = RD_MEM;
        writes_rd      = (dec.opcode == OP_LOAD);
        is_mem         = 1'b1;
      end
      OP_IMM, OP_REG: begin
        base.alu_b_sel = (dec.opcode == OP_IMM) ? ALU_B_IMM : ALU_B_REG;
        writes_rd      = 1'b1;
        case (dec.f3)
          3'b000:  base.alu_mode = (dec.opcode == OP_REG && dec.f7[5]) ? ALU_SUB : ALU_ADD;
          3'b001:  base.alu_mode = ALU_SLL;
          3'b010:  base.alu_mode = ALU_SLT;
          3'b011:  base.alu_mode = ALU_SLTU;
          3'b100:  base.alu_mode = ALU_XOR;
          3'b101:  base.alu_mode = dec.f7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  base.alu_mode = ALU_OR;
          default: base.alu_mode = ALU_AND;
        endcase
      end
      default: ;
    endcase
  end

  always_comb begin
    state_next  = state;
    fetch_start = 1'b0;
    mem_start   = 1'b0;
    ctrl        = base;
    case (state)
      FETCH: if (!debug_wait) begin
        fetch_start = 1'b1;
        state_next  = WAIT_FETCH;
      end
      WAIT_FETCH: if (fetch_done) state_next = EXECUTE;
      EXECUTE: begin
        if (is_mem) begin
          mem_start  = 1'b1;
          state_next = MEM;
        end else begin
          ctrl.rd_we   = writes_rd;
          ctrl.load_pc = is_jump;
          ctrl.step_pc = ~is_jump;
          state_next   = FETCH;
        end
      end
      MEM: if (mem_done) state_next = WRITEBACK;
      default: begin
        ctrl.rd_we   = writes_rd; // load data is latched by now.
        ctrl.step_pc = 1'b1;
        state_next   = FETCH;
      end
    endcase
  end

  assign mem_write = (dec.opcode == OP_STORE);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) state <= FETCH;
    else      state <= state_next;
  end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu
  import isa_pkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_mode_t   mode,
  output logic [31:0] y
);
  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (mode)
      ALU_ADD:    y = a + b;
      ALU_SUB:    y = a - b;
      ALU_SLL:    y = a << shamt;
      ALU_SLT:    y = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   y = {31'b0, a < b};
      ALU_XOR:    y = a ^ b;
      ALU_SRL:    y = a >> shamt;
      ALU_SRA:    y = $signed(a) >>> shamt;
      ALU_OR:     y = a | b;
      ALU_AND:    y = a & b;
      ALU_PASS_B: y = b;
      default:    y = '0;
    endcase
  end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module register_file (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [31:0] rd_data,
  input  logic        rd_we,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  output logic [31:0] regs [`CPU_REG_COUNT]
);
  // x0 is never written, so it reads as zero after reset.
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

/* source/data_access_unit.sv */
`timescale 1ns/1ps

module data_access_unit
  import bus_pkg::*;
(
  input  logic           clk,
  input  logic           rst,
  input  logic           mem_start,
  input  logic           mem_write,
  input  logic [31:0]    address,
  input  logic [31:0]    store_data,
  output avalon_rw_req_t req,
  input  avalon_rsp_t    rsp,
  output logic           done,
  output logic [31:0]    load_data
);
  logic        read_q;
  logic        write_q;
  logic [31:0] address_q;
  logic [31:0] wdata_q;

  assign done = (read_q | write_q) & ~rsp.waitrequest;
  assign req  = '{read: read_q, write: write_q, address: address_q,
                  writedata: wdata_q, byteenable: 4'hf}; // word accesses only.

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end else if (mem_start) begin
      read_q  <= ~mem_write;
      write_q <= mem_write;
    end else if (done) begin
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_start) begin
      address_q <= address;
      wdata_q   <= store_data;
    end
    if (done && read_q) load_data <= rsp.readdata; // held for the writeback cycle.
  end

endmodule

/* source/cpu.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu
  import isa_pkg::*;
  import bus_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  output avalon_read_req_t imem_req,
  input  avalon_rsp_t      imem_rsp,
  output avalon_rw_req_t   dmem_req,
  input  avalon_rsp_t      dmem_rsp,
  input  logic             debug_wait,
  output logic [31:0]      debug_pc,
  output logic [31:0]      debug_instruction,
  output logic [31:0]      debug_registers [`CPU_REG_COUNT]
);
  logic [31:0] pc;         // address of the next fetch.
  logic [31:0] current_pc; // address of the instruction in ir.
  logic [31:0] ir;
  decoded_t    dec;
  control_t    ctrl;
  logic        fetch_start, fetch_done;
  logic        mem_start, mem_write, mem_done;
  logic [31:0] rs1_data, rs2_data, rd_data;
  logic [31:0] alu_a, alu_b, alu_y;
  logic [31:0] load_data;
  logic [31:0] link_pc, branch_target;
  logic        take_branch;

  instruction_fetch_unit ifu (.clk(clk), .rst(rst), .pc(pc), .fetch_start(fetch_start),
    .req(imem_req), .rsp(imem_rsp), .done(fetch_done), .ir(ir));

  decoder dcd (.ir(ir), .dec(dec));

  control_unit cu (.clk(clk), .rst(rst), .dec(dec), .debug_wait(debug_wait),
    .fetch_done(fetch_done), .mem_done(mem_done), .fetch_start(fetch_start),
    .mem_start(mem_start), .mem_write(mem_write), .ctrl(ctrl));

  register_file rf (.clk(clk), .rst(rst), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
    .rd_data(rd_data), .rd_we(ctrl.rd_we), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .regs(debug_registers));

  assign alu_a = (ctrl.alu_a_sel == ALU_A_PC) ? current_pc : rs1_data;
  assign alu_b = (ctrl.alu_b_sel == ALU_B_IMM) ? dec.imm : rs2_data;

  alu alu_i (.a(alu_a), .b(alu_b), .mode(ctrl.alu_mode), .y(alu_y));

  data_access_unit dau (.clk(clk), .rst(rst), .mem_start(mem_start), .mem_write(mem_write),
    .address(alu_y), .store_data(rs2_data), .req(dmem_req), .rsp(dmem_rsp),
    .done(mem_done), .load_data(load_data));

  assign link_pc       = current_pc + 32'd4;
  assign branch_target = current_pc + dec.imm;
  assign take_branch   = ctrl.branch & ((alu_y != 32'd0) ^ ctrl.invert_compare);

  always_comb begin
    case (ctrl.rd_sel)
      RD_MEM:     rd_data = load_data;
      RD_NEXT_PC: rd_data = link_pc;
      default:    rd_data = alu_y;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc         <= `CPU_RESET_PC;
      current_pc <= `CPU_RESET_PC;
    end else begin
      if (ctrl.load_pc)      pc <= {alu_y[31:1], 1'b0};
      else if (ctrl.step_pc) pc <= take_branch ? branch_target : link_pc;
      if (fetch_done) current_pc <= pc;
    end
  end

  assign debug_pc          = current_pc;
  assign debug_instruction = ir;

endmodule

/* verif/avalon_memory.sv */
`timescale 1ns/1ps

module avalon_memory
  import bus_pkg::*;
(
  input  logic             clk,
  input  avalon_read_req_t imem_req,
  output avalon_rsp_t      imem_rsp,
  input  avalon_rw_req_t   dmem_req,
  output avalon_rsp_t      dmem_rsp
);
  localparam int WORDS = 256;

  // each port takes the wait states of its next transfer from the next two bits.
  localparam logic [15:0] WAIT_PATTERN = 16'b10_01_00_11_11_01_10_00;

  logic [31:0] mem [WORDS];
  int          i_wait = 0;
  int          d_wait = 0;
  logic [2:0]  i_turn = '0;
  logic [2:0]  d_turn = '0;
  logic        i_stall;
  logic        d_stall;

  assign i_stall = imem_req.read && i_wait < WAIT_PATTERN[2*i_turn +: 2];
  assign d_stall = (dmem_req.read || dmem_req.write) && d_wait < WAIT_PATTERN[2*d_turn +: 2];

  assign imem_rsp = '{waitrequest: i_stall, readdata: mem[imem_req.address[9:2]]};
  assign dmem_rsp = '{waitrequest: d_stall, readdata: mem[dmem_req.address[9:2]]};

  always @(posedge clk) begin
    if (imem_req.read) begin
      if (i_stall) begin
        i_wait <= i_wait + 1;
      end else begin
        i_wait <= 0;
        i_turn <= i_turn + 3'd1;
      end
    end
    if (dmem_req.read || dmem_req.write) begin
      if (d_stall) begin
        d_wait <= d_wait + 1;
      end else begin
        d_wait <= 0;
        d_turn <= d_turn + 3'd1;
        if (dmem_req.write) mem[dmem_req.address[9:2]] <= dmem_req.writedata;
      end
    end
  end

endmodule

/* verif/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_tb
  import bus_pkg::*;
();
  logic             clk;
  logic             rst;
  logic             debug_wait;
  avalon_read_req_t imem_req;
  avalon_rsp_t      imem_rsp;
  avalon_rw_req_t   dmem_req;
  avalon_rsp_t      dmem_rsp;
  logic [31:0]      debug_pc;
  logic [31:0]      debug_instruction;
  logic [31:0]      dut_regs [`CPU_REG_COUNT];

  logic [31:0] seed;
  logic [31:0] prog [$];
  logic [31:0] ref_regs [`CPU_REG_COUNT];
  logic [31:0] ref_mem [256];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] hold_pc_at;
  logic [31:0] final_pc;
  int          checks = 0;
  int          errors = 0;
  int          stores_seen = 0;
  int          store_waits = 0;
  logic        fetch_seen = 1'b0;
  logic        timed_out = 1'b0;

  cpu uut (.clk(clk), .rst(rst), .imem_req(imem_req), .imem_rsp(imem_rsp),
    .dmem_req(dmem_req), .dmem_rsp(dmem_rsp), .debug_wait(debug_wait),
    .debug_pc(debug_pc), .debug_instruction(debug_instruction), .debug_registers(dut_regs));

  avalon_memory mem_model (.clk(clk), .imem_req(imem_req), .imem_rsp(imem_rsp),
    .dmem_req(dmem_req), .dmem_rsp(dmem_rsp));

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] alu_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (expected === actual)
      else begin
        errors++;
        $display("** Error %s: expected %h, actual %h", name, expected, actual);
      end
  endtask

  task automatic expect_true(logic ok, string what);
    checks++;
    assert (ok)
      else begin
        errors++;
        $display("%s", what);
      end
  endtask

  task automatic put(logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic build_program();
    logic [31:0] r;
    int          rd;
    int          f3;
    for (int k = 1; k <= 8; k++) begin
      r = xorshift32();
      put(u_type(r[31:12], k, 7'h37));
      put(i_type(r[11:0], k, 3'd0, k, 7'h13));
    end
    put(r_type(7'h00, 2, 1, 3'd0, 0, 7'h33)); // writes to x0 must be dropped.
    put(i_type(12'h7ff, 3, 3'd0, 0, 7'h13));
    for (int k = 0; k < 24; k++) begin
      r  = xorshift32();
      rd = 9 + r[4:0] % 20;
      f3 = r[13:11];
      if (r[14])
        put(r_type({1'b0, r[15] & (f3 == 0 || f3 == 5), 5'b0}, 1 + r[10:8], 1 + r[7:5],
                   f3, rd, 7'h33));
      else if (f3 == 1 || f3 == 5)
        put(i_type({1'b0, r[15] & (f3 == 5), 5'b0, r[20:16]}, 1 + r[7:5], f3, rd, 7'h13));
      else
        put(i_type(r[31:20], 1 + r[7:5], f3, rd, 7'h13));
    end
    r = xorshift32();
    put(u_type(r[31:12], 29, 7'h17));
    hold_pc_at = prog.size() * 4;
    // each branch jumps over one marker that sets its own bit of x30.
    for (int j = 0; j < 12; j++) begin
      f3 = (j < 4) ? j / 2 : j / 2 + 2;
      put(b_type(13'd8, j[0] ? 5'd3 : 5'd2, j[0] ? 5'd3 : 5'd1, f3));
      put(i_type(12'(1 << j), 30, 3'd0, 30, 7'h13));
    end
    put(j_type(21'd8, 31));
    put(i_type(12'h100, 30, 3'd0, 30, 7'h13));
    put(u_type(20'd0, 28, 7'h17));
    put(i_type(12'd13, 28, 3'd0, 27, 7'h67)); // jalr clears the low bit of the odd target.
    put(i_type(12'h200, 30, 3'd0, 30, 7'h13));
    put(i_type(12'h200, 0, 3'd0, 10, 7'h13));
    put(s_type(12'd0, 1, 10));
    put(s_type(12'd4, 2, 10));
    put(i_type(12'd0, 10, 3'd2, 11, 7'h03));
    put(i_type(12'd4, 10, 3'd2, 12, 7'h03));
    put(i_type(12'd8, 10, 3'd2, 13, 7'h03));
    for (int k = 0; k < 4; k++) begin
      r = xorshift32();
      put(s_type({4'b0, r[7:2], 2'b00}, 3 + k, 10));
      put(i_type({4'b0, r[7:2], 2'b00}, 10, 3'd2, 14 + k, 7'h03));
    end
    final_pc = prog.size() * 4;
    put(j_type(21'd0, 0));
  endtask

  task automatic run_model();
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic        alt;
    logic        wr;
    int          steps;
    pc    = `CPU_RESET_PC;
    steps = 0;
    for (int i = 0; i < `CPU_REG_COUNT; i++)
      ref_regs[i] = '0;
    ins = ref_mem[pc[9:2]];
    while (ins != 32'h0000_006f && steps < 1000) begin
      a       = ref_regs[ins[19:15]];
      b       = ref_regs[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      res     = pc + 4;
      next_pc = pc + 4;
      wr      = 1'b1;
      alt     = ins[30] && (ins[5] || ins[14:12] == 3'd5); // sub, sra and srai.
      case (ins[6:0])
        7'h37: res = {ins[31:12], 12'h000};
        7'h17: res = pc + {ins[31:12], 12'h000};
        7'h6f: next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        7'h67: next_pc = (a + imm_i) & ~32'd1;
        7'h63: begin
          wr = 1'b0;
          if (branch_taken(ins[14:12], a, b))
            next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        7'h03: begin
          addr = a + imm_i;
          res  = ref_mem[addr[9:2]];
        end
        7'h23: begin
          wr   = 1'b0;
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          ref_mem[addr[9:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        7'h13: res = alu_op(ins[14:12], alt, a, imm_i);
        7'h33: res = alu_op(ins[14:12], alt, a, b);
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) ref_regs[ins[11:7]] = res;
      pc  = next_pc;
      ins = ref_mem[pc[9:2]];
      steps++;
    end
    expect_true(steps < 1000, "the reference model never reached the final jump");
  endtask

  task automatic wait_for_pc(logic [31:0] target, int limit);
    int n;
    n = 0;
    while (debug_pc !== target && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (debug_pc !== target) begin
      timed_out = 1'b1;
      $display("timeout while waiting for the core to reach pc %h", target);
    end
  endtask

  task automatic hold_core();
    logic [31:0] held_pc;
    @(posedge clk);
    #2 debug_wait = 1'b1;
    repeat (16) @(negedge clk); // longer than the slowest instruction.
    held_pc = debug_pc;
    for (int n = 0; n < 20; n++) begin
      @(negedge clk);
      check_value("pc under debug_wait", held_pc, debug_pc);
      check_value("instruction under debug_wait", prog[held_pc[9:2]], debug_instruction);
      expect_true(!imem_req.read, "instruction read issued while debug_wait was high");
    end
    @(posedge clk);
    #2 debug_wait = 1'b0;
  endtask

  task automatic wait_for_finish(int limit);
    int stable;
    int n;
    stable = 0;
    n      = 0;
    while (stable < 20 && n < limit) begin
      @(negedge clk);
      n++;
      stable = (debug_pc === final_pc) ? stable + 1 : 0;
    end
    if (stable < 20) begin
      timed_out = 1'b1;
      $display("timeout while waiting for the program to settle on its final jump");
    end
  endtask

  task automatic compare_state();
    for (int i = 0; i < `CPU_REG_COUNT; i++)
      check_value($sformatf("register x%0d", i), ref_regs[i], dut_regs[i]);
    for (int i = 0; i < 256; i++)
      check_value($sformatf("memory word %0d", i), ref_mem[i], mem_model.mem[i]);
    check_value("write transfer count", exp_addr.size(), stores_seen);
    expect_true(store_waits > 0, "no write transfer was stretched by waitrequest");
  endtask

  // the bus is sampled half a cycle away from the edges that change it.
  always @(negedge clk) begin
    if (rst && imem_req.read && !fetch_seen) begin
      fetch_seen = 1'b1;
      check_value("first fetch address", `CPU_RESET_PC, imem_req.address);
    end
    if (rst && dmem_req.write) begin
      expect_true(stores_seen < exp_addr.size(), "write transfer beyond the expected stores");
      if (stores_seen < exp_addr.size()) begin
        check_value("store address", exp_addr[stores_seen], dmem_req.address);
        check_value("store data", exp_data[stores_seen], dmem_req.writedata);
      end
      check_value("store byteenable", 32'h0000_000f, dmem_req.byteenable);
      if (dmem_rsp.waitrequest) store_waits++;
      else stores_seen++;
    end
  end

  initial begin
    rst        = 1'b0;
    debug_wait = 1'b0;
    seed       = 32'd13648;
    build_program();
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 32'h9e37_79b9 * (i * 4 + 1); // fill value follows the byte address.
      if (i < prog.size()) ref_mem[i] = prog[i];
      mem_model.mem[i] = ref_mem[i];
    end
    run_model();
    @(posedge clk);
    @(negedge clk);
    expect_true(!imem_req.read && !dmem_req.read && !dmem_req.write,
                "bus request raised while reset was active");
    @(posedge clk);
    #2 rst = 1'b1;
    wait_for_pc(hold_pc_at, 2000);
    if (!timed_out) hold_core();
    if (!timed_out) wait_for_finish(5000);
    if (!timed_out) compare_state();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
source/isa_pkg.sv
source/bus_pkg.sv
source/instruction_fetch_unit.sv
source/decoder.sv
source/control_unit.sv
source/alu.sv
source/register_file.sv
source/data_access_unit.sv
source/cpu.sv
verif/avalon_memory.sv
verif/cpu_tb.sv
